// ==== src/pu_div_pkg.sv ====
package pu_div_pkg;

  // operand and bus widths
  localparam int DATA_WIDTH = 16;
  localparam int WB_WIDTH   = 32;
  localparam int ADDR_WIDTH = 3;

  // attribute field, invalid flag position
  localparam int ATTR_WIDTH  = 4;
  localparam int INVALID_BIT = 0;

  // write data bit carrying the operand's invalid attribute
  localparam int ATTR_IN_BIT = 16;

  // divider pipeline
  localparam int DIV_STAGES    = 4;
  localparam int STEP_BITS     = DATA_WIDTH / DIV_STAGES;
  localparam int DIV_LATENCY   = DIV_STAGES + 1;
  localparam int LAT_CNT_WIDTH = $clog2(DIV_LATENCY);

  // status register bits
  localparam int STAT_BUSY_BIT    = 0;
  localparam int STAT_INVALID_BIT = 1;

  typedef logic [DATA_WIDTH-1:0] data_t;
  typedef logic [ATTR_WIDTH:0]   attr_t;

  // word addresses of the register map
  typedef enum logic [ADDR_WIDTH-1:0] {
    ADDR_NUMER  = 3'd0,
    ADDR_DENOM  = 3'd1,
    ADDR_STATUS = 3'd2,
    ADDR_QUOT   = 3'd3,
    ADDR_REM    = 3'd4
  } reg_addr_t;

  typedef enum logic [1:0] {SEQ_IDLE, SEQ_BUSY, SEQ_READ} seq_state_t;

endpackage

// ==== src/pu_ctrl_if.sv ====
interface pu_ctrl_if;
  import pu_div_pkg::*;

  // operand load
  logic  signal_wr;
  logic  signal_sel;
  data_t data_in;
  attr_t attr_in;

  // result access
  logic  res_select;
  logic  signal_oe;
  data_t data_out;
  attr_t attr_out;

  modport ctrl (
    output signal_wr,
    output signal_sel,
    output data_in,
    output attr_in,
    output res_select,
    output signal_oe,
    input  data_out,
    input  attr_out
  );

  modport unit (
    input  signal_wr,
    input  signal_sel,
    input  data_in,
    input  attr_in,
    input  res_select,
    input  signal_oe,
    output data_out,
    output attr_out
  );

endinterface

// ==== src/div_pipe.sv ====
module div_pipe (
  input  logic              clk,
  input  logic              rst,
  input  pu_div_pkg::data_t numer,
  input  pu_div_pkg::data_t denom,
  output pu_div_pkg::data_t quotient,
  output pu_div_pkg::data_t remain
);
  import pu_div_pkg::*;

  // stage 0 is the input register, stage DIV_STAGES holds the result
  data_t rem_q [DIV_STAGES+1];
  data_t quo_q [DIV_STAGES+1];
  data_t div_q [DIV_STAGES+1];

  data_t nxt_rem [DIV_STAGES];
  data_t nxt_quo [DIV_STAGES];

  // STEP_BITS restoring steps, numerator bits shift out of quo as quotient bits shift in
  function automatic logic [2*DATA_WIDTH-1:0] div_steps(
    input data_t rem_in,
    input data_t quo_in,
    input data_t divisor
  );
    logic [DATA_WIDTH:0] trial;
    data_t               r;
    data_t               q;
    r = rem_in;
    q = quo_in;
    for (int i = 0; i < STEP_BITS; i++) begin
      trial = {r, q[DATA_WIDTH-1]};
      q     = q << 1;
      if (trial >= {1'b0, divisor}) begin
        trial = trial - {1'b0, divisor};
        q[0]  = 1'b1;
      end
      // fits after a subtract, or when trial already below divisor
      r = trial[DATA_WIDTH-1:0];
    end
    return {r, q};
  endfunction

  for (genvar k = 0; k < DIV_STAGES; k++) begin : g_stage
    assign {nxt_rem[k], nxt_quo[k]} = div_steps(rem_q[k], quo_q[k], div_q[k]);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int k = 0; k <= DIV_STAGES; k++) begin
        rem_q[k] <= '0;
        quo_q[k] <= '0;
        div_q[k] <= '0;
      end
    end else begin
      // first stage starts from an empty remainder
      rem_q[0] <= '0;
      quo_q[0] <= numer;
      div_q[0] <= denom;
      for (int k = 1; k <= DIV_STAGES; k++) begin
        rem_q[k] <= nxt_rem[k-1];
        quo_q[k] <= nxt_quo[k-1];
        div_q[k] <= div_q[k-1];
      end
    end
  end

  assign quotient = quo_q[DIV_STAGES];
  assign remain   = rem_q[DIV_STAGES];

endmodule

// ==== src/pu_div.sv ====
module pu_div (
  input logic      clk,
  input logic      rst,
  pu_ctrl_if.unit  ctl
);
  import pu_div_pkg::*;

  // operand registers feeding the divider
  data_t arg_numer;
  data_t arg_denom;
  logic  attr_numer;
  logic  attr_denom;

  // first step of the two-step load
  data_t arg_latch;
  logic  attr_latch;

  // set once a full operand pair has been loaded
  logic  arg_valid;

  logic [DIV_STAGES-1:0] inv_pipe;

  data_t quotient_res;
  data_t remain_res;
  data_t data_res;
  logic  inv_res;
  attr_t attr_res;

  always_ff @(posedge clk) begin
    if (rst) begin
      arg_latch  <= '0;
      attr_latch <= 1'b0;
      arg_numer  <= '0;
      arg_denom  <= '0;
      attr_numer <= 1'b0;
      attr_denom <= 1'b0;
      arg_valid  <= 1'b0;
    end else if (ctl.signal_wr && !ctl.signal_sel) begin
      arg_latch  <= ctl.data_in;
      attr_latch <= ctl.attr_in[INVALID_BIT];
    end else if (ctl.signal_wr && ctl.signal_sel) begin
      // denominator strobe launches the pair
      arg_numer  <= arg_latch;
      attr_numer <= attr_latch;
      arg_denom  <= ctl.data_in;
      attr_denom <= ctl.attr_in[INVALID_BIT];
      arg_valid  <= 1'b1;
    end
  end

  // invalid flag follows the operands down the pipeline
  always_ff @(posedge clk) begin
    if (rst) begin
      inv_pipe <= '0;
    end else begin
      inv_pipe <= {inv_pipe[DIV_STAGES-2:0],
                   arg_valid && (attr_numer || attr_denom || arg_denom == '0)};
    end
  end

  div_pipe div_pipe_i (
    .clk      (clk),
    .rst      (rst),
    .numer    (arg_numer),
    .denom    (arg_denom),
    .quotient (quotient_res),
    .remain   (remain_res)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      data_res <= '0;
      inv_res  <= 1'b0;
    end else if (ctl.signal_oe) begin
      inv_res <= inv_pipe[DIV_STAGES-1];
      // nothing computed yet reads back as zero
      if (!arg_valid) begin
        data_res <= '0;
      end else if (ctl.res_select) begin
        data_res <= quotient_res;
      end else begin
        data_res <= remain_res;
      end
    end
  end

  always_comb begin
    attr_res              = '0;
    attr_res[INVALID_BIT] = inv_res;
  end

  // outputs only carry data while enabled
  assign ctl.data_out = ctl.signal_oe ? data_res : '0;
  assign ctl.attr_out = ctl.signal_oe ? attr_res : '0;

endmodule

// ==== src/div_regs.sv ====
module div_regs (
  input  logic                            clk,
  input  logic                            rst,
  input  logic [pu_div_pkg::ADDR_WIDTH-1:0] adr,
  input  logic [pu_div_pkg::WB_WIDTH-1:0]   dat_w,
  input  logic                            we,
  input  logic                            cyc,
  input  logic                            stb,
  output logic [pu_div_pkg::WB_WIDTH-1:0]   dat_r,
  output logic                            ack,
  pu_ctrl_if.ctrl                         ctl
);
  import pu_div_pkg::*;

  seq_state_t               state;
  logic [LAT_CNT_WIDTH-1:0] lat_cnt;
  logic                     inv_q;

  reg_addr_t                addr;
  logic                     req;
  logic                     is_operand;
  logic                     is_result;
  logic                     busy;
  logic [WB_WIDTH-1:0]      status_word;
  logic [WB_WIDTH-1:0]      reg_rdata;

  assign addr       = reg_addr_t'(adr);
  // open cycle not yet answered
  assign req        = cyc && stb && !ack;
  assign is_operand = (addr == ADDR_NUMER) || (addr == ADDR_DENOM);
  assign is_result  = (addr == ADDR_QUOT) || (addr == ADDR_REM);
  assign busy       = (state == SEQ_BUSY);

  always_comb begin
    status_word                   = '0;
    status_word[STAT_BUSY_BIT]    = busy;
    status_word[STAT_INVALID_BIT] = inv_q;
  end

  // operands are write only
  assign reg_rdata = (addr == ADDR_STATUS) ? status_word : '0;

  // operand path to the unit
  assign ctl.signal_wr  = req && we && is_operand;
  assign ctl.signal_sel = (addr == ADDR_DENOM);
  assign ctl.data_in    = dat_w[DATA_WIDTH-1:0];

  always_comb begin
    ctl.attr_in              = '0;
    ctl.attr_in[INVALID_BIT] = dat_w[ATTR_IN_BIT];
  end

  // result enable raised on the idle request and held through SEQ_READ
  assign ctl.res_select = (addr == ADDR_QUOT);
  assign ctl.signal_oe  = (state == SEQ_IDLE && req && !we && is_result) ||
                          (state == SEQ_READ);

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= SEQ_IDLE;
      lat_cnt <= '0;
      ack     <= 1'b0;
      dat_r   <= '0;
      inv_q   <= 1'b0;
    end else begin
      ack <= 1'b0;
      case (state)
        SEQ_IDLE, SEQ_BUSY: begin
          if (state == SEQ_BUSY) begin
            if (lat_cnt == '0) begin
              state <= SEQ_IDLE;
            end else begin
              lat_cnt <= lat_cnt - 1'b1;
            end
          end
          if (req) begin
            if (we || !is_result) begin
              ack <= 1'b1;
              if (!we) begin
                dat_r <= reg_rdata;
              end
              // new denominator restarts the latency count
              if (we && addr == ADDR_DENOM) begin
                state   <= SEQ_BUSY;
                lat_cnt <= LAT_CNT_WIDTH'(DIV_LATENCY - 1);
              end
            end else if (state == SEQ_IDLE) begin
              state <= SEQ_READ;
            end
            // result read while busy waits here
          end
        end
        SEQ_READ: begin
          ack   <= 1'b1;
          dat_r <= {{(WB_WIDTH-DATA_WIDTH){1'b0}}, ctl.data_out};
          inv_q <= ctl.attr_out[INVALID_BIT];
          state <= SEQ_IDLE;
        end
        default: state <= SEQ_IDLE;
      endcase
    end
  end

endmodule

// ==== src/pu_div_top.sv ====
module pu_div_top (
  input  logic                              clk,
  input  logic                              rst,
  input  logic [pu_div_pkg::ADDR_WIDTH-1:0] adr,
  input  logic [pu_div_pkg::WB_WIDTH-1:0]   dat_w,
  input  logic                              we,
  input  logic                              cyc,
  input  logic                              stb,
  output logic [pu_div_pkg::WB_WIDTH-1:0]   dat_r,
  output logic                              ack
);

  // control and data between register block and unit
  pu_ctrl_if ctl_if ();

  div_regs div_regs_i (
    .clk   (clk),
    .rst   (rst),
    .adr   (adr),
    .dat_w (dat_w),
    .we    (we),
    .cyc   (cyc),
    .stb   (stb),
    .dat_r (dat_r),
    .ack   (ack),
    .ctl   (ctl_if.ctrl)
  );

  pu_div pu_div_i (
    .clk (clk),
    .rst (rst),
    .ctl (ctl_if.unit)
  );

endmodule

// ==== test/tb_pu_div_top.sv ====
module tb_pu_div_top;
  timeunit 1ns;
  timeprecision 100ps;
  import pu_div_pkg::*;

  typedef struct packed {
    data_t numer;
    logic  numer_attr;
    data_t denom;
    logic  denom_attr;
    data_t quot;
    data_t rem;
    logic  inv;
  } div_case_t;

  logic                  clk;
  logic                  rst;
  logic [ADDR_WIDTH-1:0] adr;
  logic [WB_WIDTH-1:0]   dat_w;
  logic                  we;
  logic                  cyc;
  logic                  stb;
  logic [WB_WIDTH-1:0]   dat_r;
  logic                  ack;

  div_case_t cases [$];
  bit        cases_loaded;

  pu_div_top pu_div_top_i (
    .clk   (clk),
    .rst   (rst),
    .adr   (adr),
    .dat_w (dat_w),
    .we    (we),
    .cyc   (cyc),
    .stb   (stb),
    .dat_r (dat_r),
    .ack   (ack)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("TEST RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic check_data(input string name, input data_t actual, input data_t expected);
    if (actual !== expected) begin
      abort_run($sformatf("CHECK FAILED at %0d ns: %s is 0x%h, expected 0x%h",
                          $time, name, actual, expected));
    end
  endtask

  task automatic check_flag(input string name, input bit actual, input bit expected);
    if (actual !== expected) begin
      abort_run($sformatf("CHECK FAILED at %0d ns: %s is %b, expected %b",
                          $time, name, actual, expected));
    end
  endtask

  // operand in the low half with its attribute at ATTR_IN_BIT
  function automatic logic [WB_WIDTH-1:0] operand_word(input data_t value, input logic attr);
    logic [WB_WIDTH-1:0] word;
    word                   = '0;
    word[DATA_WIDTH-1:0]   = value;
    word[ATTR_IN_BIT]      = attr;
    return word;
  endfunction

  // numer = quot * denom + rem with rem < denom
  // divide by zero gives all ones and the numerator
  function automatic bit case_obeys_rule(input div_case_t c);
    logic [31:0] rebuilt;
    bit          inv_rule;
    rebuilt  = 32'(c.quot) * 32'(c.denom) + 32'(c.rem);
    inv_rule = c.numer_attr || c.denom_attr || (c.denom == '0);
    if (c.inv != inv_rule) return 1'b0;
    if (c.denom == '0) return (c.quot == '1) && (c.rem == c.numer);
    return (rebuilt == 32'(c.numer)) && (c.rem < c.denom);
  endfunction

  task automatic wb_write(input reg_addr_t addr, input logic [WB_WIDTH-1:0] data);
    @(negedge clk);
    adr   = addr;
    dat_w = data;
    we    = 1'b1;
    cyc   = 1'b1;
    stb   = 1'b1;
    @(negedge clk);
    while (!ack) @(negedge clk);
    cyc = 1'b0;
    stb = 1'b0;
    we  = 1'b0;
  endtask

  task automatic wb_read(input reg_addr_t addr, output logic [WB_WIDTH-1:0] data);
    @(negedge clk);
    adr = addr;
    we  = 1'b0;
    cyc = 1'b1;
    stb = 1'b1;
    @(negedge clk);
    while (!ack) @(negedge clk);
    data = dat_r;
    cyc  = 1'b0;
    stb  = 1'b0;
  endtask

  task automatic load_cases();
    int          fd;
    int          n;
    int          r;
    string       line;
    logic [31:0] f_numer;
    logic [31:0] f_nattr;
    logic [31:0] f_denom;
    logic [31:0] f_dattr;
    logic [31:0] f_quot;
    logic [31:0] f_rem;
    logic [31:0] f_inv;
    div_case_t   c;
    fd = $fopen("test/pu_div_testdata.txt", "r");
    if (fd == 0) abort_run("cannot open test/pu_div_testdata.txt");
    while (!$feof(fd)) begin
      line = "";
      r    = $fgets(line, fd);
      n    = 0;
      // comment and blank lines yield no fields
      if (r > 0) begin
        n = $sscanf(line, "%h %h %h %h %h %h %h",
                    f_numer, f_nattr, f_denom, f_dattr, f_quot, f_rem, f_inv);
      end
      if (n == 7) begin
        c.numer      = f_numer[DATA_WIDTH-1:0];
        c.numer_attr = f_nattr[0];
        c.denom      = f_denom[DATA_WIDTH-1:0];
        c.denom_attr = f_dattr[0];
        c.quot       = f_quot[DATA_WIDTH-1:0];
        c.rem        = f_rem[DATA_WIDTH-1:0];
        c.inv        = f_inv[0];
        if (!case_obeys_rule(c)) begin
          abort_run($sformatf("test data case %0d breaks the division rule", cases.size()));
        end
        cases.push_back(c);
      end else if (n > 0) begin
        abort_run("malformed line in test data, seven hex fields expected");
      end
    end
    $fclose(fd);
    if (cases.size() == 0) abort_run("test data holds no division cases");
  endtask

  task automatic run_case(input div_case_t c, input int idx);
    logic [WB_WIDTH-1:0] rd;
    wb_write(ADDR_NUMER, operand_word(c.numer, c.numer_attr));
    wb_write(ADDR_DENOM, operand_word(c.denom, c.denom_attr));
    // every other case polls status while the divider runs
    if (idx % 2 == 0) begin
      wb_read(ADDR_STATUS, rd);
      check_flag($sformatf("case %0d busy after denominator", idx), rd[STAT_BUSY_BIT], 1'b1);
    end
    // issued while busy so ack has to wait for the result
    wb_read(ADDR_QUOT, rd);
    check_data($sformatf("case %0d quotient", idx), rd[DATA_WIDTH-1:0], c.quot);
    check_data($sformatf("case %0d quotient upper", idx), rd[WB_WIDTH-1:DATA_WIDTH], '0);
    wb_read(ADDR_REM, rd);
    check_data($sformatf("case %0d remainder", idx), rd[DATA_WIDTH-1:0], c.rem);
    wb_read(ADDR_STATUS, rd);
    check_flag($sformatf("case %0d busy", idx), rd[STAT_BUSY_BIT], 1'b0);
    check_flag($sformatf("case %0d invalid", idx), rd[STAT_INVALID_BIT], c.inv);
  endtask

  initial begin : watchdog
    wait (cases_loaded);
    repeat (cases.size() * 40 + 100) @(posedge clk);
    abort_run("watchdog expired, the DUT stopped answering bus cycles");
  end

  initial begin : main
    logic [WB_WIDTH-1:0] rd;
    rst   = 1'b1;
    adr   = '0;
    dat_w = '0;
    we    = 1'b0;
    cyc   = 1'b0;
    stb   = 1'b0;
    load_cases();
    cases_loaded = 1'b1;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    check_flag("ack after reset", ack, 1'b0);

    // nothing computed yet
    wb_read(ADDR_STATUS, rd);
    check_data("status after reset", rd[DATA_WIDTH-1:0], '0);
    wb_read(ADDR_QUOT, rd);
    check_data("quotient after reset", rd[DATA_WIDTH-1:0], '0);
    wb_read(ADDR_REM, rd);
    check_data("remainder after reset", rd[DATA_WIDTH-1:0], '0);
    // result reads without an operation leave invalid clear
    wb_read(ADDR_STATUS, rd);
    check_flag("invalid after reset reads", rd[STAT_INVALID_BIT], 1'b0);

    for (int i = 0; i < cases.size(); i++) begin
      run_case(cases[i], i);
    end

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

// ==== pu_div_system.f ====
src/pu_div_pkg.sv
src/pu_ctrl_if.sv
src/div_pipe.sv
src/pu_div.sv
src/div_regs.sv
src/pu_div_top.sv
test/tb_pu_div_top.sv

// ==== Makefile ====
# Verilator build and run of the pu_div_system testbench

SIM      = verilator
FLAGS    = --binary --timing -j 0
TOP      = tb_pu_div_top
FILELIST = pu_div_system.f
BUILD    = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with $(SIM) and run it"
	@echo "  clean  remove the build directory"

# the run exits non-zero when the testbench fails
test: $(BUILD)/V$(TOP)
	./$(BUILD)/V$(TOP)

$(BUILD)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(SIM) $(FLAGS) --top-module $(TOP) -Mdir $(BUILD) -f $(FILELIST)

clean:
	rm -rf $(BUILD)

// ==== test/pu_div_testdata.txt ====
# numer numer_attr denom denom_attr quotient remainder invalid, all hex
# one division per line, invalid set for a zero denominator or either attribute
0064 0 0007 0 000e 0002 0
ffff 0 0001 0 ffff 0000 0
ffff 0 ffff 0 0001 0000 0
1234 0 0000 0 ffff 1234 1
0005 0 0003 0 0001 0002 0
0000 0 0005 0 0000 0000 0
0003 0 0008 0 0000 0003 0
03e8 1 000a 0 0064 0000 1
0050 0 0009 0 0008 0008 0
1000 0 0010 1 0100 0000 1
c350 0 00c8 0 00fa 0000 0
0000 0 0000 0 ffff 0000 1
abcd 0 0100 0 00ab 00cd 0
8000 0 0003 0 2aaa 0002 0
fffe 0 7fff 0 0002 0000 0
ffff 0 8000 0 0001 7fff 0
7fff 1 0000 1 ffff 7fff 1
2710 0 0007 0 0594 0004 0
00ff 0 0010 0 000f 000f 0
04d2 0 0022 0 0024 000a 0
0001 0 0001 1 0001 0000 1
9c40 0 0000 0 ffff 9c40 1
0064 0 0064 0 0001 0000 0
